// File: design/uart_pkg.sv
`default_nettype none

package uart_pkg;

  localparam int CMD_W  = 16;
  localparam int BYTE_W = 8;
  localparam int CNT_W  = 7;
  localparam int STAT_W = 2;

  localparam int BIT_CYCLES       = 434;                // Clocks per bit
  localparam int MID_CYCLES       = BIT_CYCLES / 2;
  localparam int CYC_W            = $clog2(BIT_CYCLES);
  localparam int FRAME_BITS       = 11;                 // Start, 8 data, parity, stop
  localparam int IDX_W            = $clog2(FRAME_BITS);
  localparam int GAP_BITS         = 2;
  localparam int RSP_TIMEOUT_BITS = 64;

  typedef logic [CMD_W-1:0]  cmd_t;        // [15] write, [14:8] addr, [7:0] data
  typedef logic [BYTE_W-1:0] uart_byte_t;
  typedef logic [CNT_W-1:0]  bit_count_t;
  typedef logic [STAT_W-1:0] rsp_status_t;
  typedef logic [CYC_W-1:0]  cycle_t;
  typedef logic [IDX_W-1:0]  frame_idx_t;

  localparam rsp_status_t STAT_OK      = 2'd0;
  localparam rsp_status_t STAT_PARITY  = 2'd1;
  localparam rsp_status_t STAT_FRAME   = 2'd2;
  localparam rsp_status_t STAT_TIMEOUT = 2'd3;

  typedef enum logic [2:0] {
    IDLE,
    SEND_ADDR,
    GAP,
    SEND_DATA,
    WAIT_RSP,
    RECV_RSP,
    FINISH
  } bridge_state_t;

endpackage

`default_nettype wire

// File: design/baud_timer.sv
`timescale 1ns/1ps
`default_nettype none

module baud_timer
  import uart_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  input  wire        timer_clr,
  input  wire        timer_run,
  output logic       bit_tick,
  output logic       mid_tick,
  output bit_count_t bit_cnt
);

  cycle_t cyc_q;

  // Both ticks are single-cycle strobes decoded from the cycle counter
  assign bit_tick = timer_run && (cyc_q == cycle_t'(BIT_CYCLES - 1));
  assign mid_tick = timer_run && (cyc_q == cycle_t'(MID_CYCLES));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cyc_q   <= '0;
      bit_cnt <= '0;
    end
    else if (timer_clr)
    begin
      cyc_q   <= '0;                     // Next period starts here
      bit_cnt <= '0;
    end
    else if (timer_run)
    begin
      if (bit_tick)
      begin
        cyc_q <= '0;
      end
      else
      begin
        cyc_q <= cyc_q + 1'b1;
      end
      if (bit_tick && (bit_cnt != '1))
      begin
        bit_cnt <= bit_cnt + 1'b1;       // Saturates at top
      end
    end
  end

endmodule

`default_nettype wire

// File: design/uart_tx_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_shifter
  import uart_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  input  wire        tx_load,
  input  uart_byte_t tx_byte,
  input  wire        bit_tick,
  output logic       tx,
  output logic       tx_busy
);

  logic [FRAME_BITS-1:0] frame;
  logic [FRAME_BITS-1:0] shift_q;
  frame_idx_t            sent_q;

  // Stop, even parity, data LSB first, start
  assign frame = {1'b1, ^tx_byte, tx_byte, 1'b0};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shift_q <= '1;                    // Line idles high
      sent_q  <= '0;
      tx_busy <= 1'b0;
    end
    else if (tx_load)
    begin
      shift_q <= frame;
      sent_q  <= '0;
      tx_busy <= 1'b1;
    end
    else if (tx_busy && bit_tick)
    begin
      shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]};
      if (sent_q == frame_idx_t'(FRAME_BITS - 1))
      begin
        sent_q  <= '0;
        tx_busy <= 1'b0;                // Stop period complete
      end
      else
      begin
        sent_q <= sent_q + 1'b1;
      end
    end
  end

  // Output flop keeps tx glitch free
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx <= 1'b1;
    end
    else
    begin
      tx <= shift_q[0];
    end
  end

endmodule

`default_nettype wire

// File: design/uart_rx_sampler.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_sampler
  import uart_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  input  wire        rx,
  input  wire        rx_arm,
  input  wire        mid_tick,
  output logic       start_seen,
  output logic       rx_done,
  output uart_byte_t rx_byte,
  output logic       parity_ok,
  output logic       stop_ok
);

  logic       rx_meta;
  logic       rx_sync;
  logic       rx_prev;
  logic       receiving;
  logic       par_bit;
  frame_idx_t bit_idx;

  // Two-flop synchronizer plus one flop for edge detect
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign start_seen = rx_arm && !receiving && rx_prev && !rx_sync;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      receiving <= 1'b0;
      bit_idx   <= '0;
      rx_done   <= 1'b0;
    end
    else
    begin
      rx_done <= 1'b0;
      if (!rx_arm)
      begin
        receiving <= 1'b0;
      end
      else if (start_seen)
      begin
        receiving <= 1'b1;
        bit_idx   <= '0;
      end
      else if (receiving && mid_tick)
      begin
        if ((bit_idx == '0) && rx_sync)
        begin
          receiving <= 1'b0;                       // False start, rearm
        end
        else if (bit_idx == frame_idx_t'(FRAME_BITS - 1))
        begin
          receiving <= 1'b0;
          rx_done   <= 1'b1;
        end
        else
        begin
          bit_idx <= bit_idx + 1'b1;
        end
      end
    end
  end

  // Payload and check results, valid with rx_done
  always_ff @(posedge clk)
  begin
    if (receiving && mid_tick && (bit_idx != '0))
    begin
      if (bit_idx <= frame_idx_t'(BYTE_W))
      begin
        rx_byte <= {rx_sync, rx_byte[BYTE_W-1:1]};   // LSB arrives first
      end
      else if (bit_idx == frame_idx_t'(BYTE_W + 1))
      begin
        par_bit <= rx_sync;
      end
      else
      begin
        stop_ok   <= rx_sync;
        parity_ok <= (^rx_byte) == par_bit;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/uart_cmd_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_fsm
  import uart_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n,
  input  cmd_t        cmd_in,
  input  wire         cmd_vld,
  output logic        cmd_rdy,
  output uart_byte_t  read_data,
  output rsp_status_t read_status,
  output logic        read_vld,
  output logic        timer_clr,
  output logic        timer_run,
  input  wire         bit_tick,
  input  bit_count_t  bit_cnt,
  output logic        tx_load,
  output uart_byte_t  tx_byte,
  input  wire         tx_busy,
  output logic        rx_arm,
  input  wire         start_seen,
  input  wire         rx_done,
  input  uart_byte_t  rx_byte,
  input  wire         parity_ok,
  input  wire         stop_ok
);

  bridge_state_t state_q;
  bridge_state_t state_d;
  cmd_t          cmd_buf;
  logic          launch_q;
  logic          accept;
  logic          frame_end;
  logic          gap_end;
  logic          rsp_wait;
  logic          rsp_done;
  logic          rsp_timeout;
  rsp_status_t   rx_status;

  assign accept    = cmd_vld && cmd_rdy;
  assign frame_end = bit_tick && (bit_cnt == bit_count_t'(FRAME_BITS - 1));   // 11th tick
  assign gap_end   = bit_tick && (bit_cnt == bit_count_t'(GAP_BITS - 1));
  assign rsp_wait  = (state_q == WAIT_RSP) || (state_q == RECV_RSP);
  assign rsp_done  = (state_q == RECV_RSP) && rx_done;
  assign rsp_timeout = rsp_wait && !rsp_done && !start_seen &&
                       (bit_cnt == bit_count_t'(RSP_TIMEOUT_BITS));

  // Stop error outranks parity error
  assign rx_status = !stop_ok   ? STAT_FRAME  :
                     !parity_ok ? STAT_PARITY : STAT_OK;

  // Every load restarts the timer so ticks line up with the frame
  assign tx_load   = launch_q || ((state_q == GAP) && gap_end);
  assign tx_byte   = launch_q ? cmd_buf[CMD_W-1:BYTE_W] : cmd_buf[BYTE_W-1:0];
  assign timer_run = state_q != IDLE;
  assign timer_clr = (state_q == IDLE) || tx_load ||
                     ((state_q == SEND_ADDR) && frame_end) || start_seen;
  assign rx_arm    = rsp_wait;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
        if (accept)
          state_d = SEND_ADDR;
      SEND_ADDR:
        if (frame_end)
          state_d = cmd_buf[CMD_W-1] ? GAP : WAIT_RSP;   // Write flag picks the path
      GAP:
        if (gap_end)
          state_d = SEND_DATA;
      SEND_DATA:
        if (frame_end)
          state_d = FINISH;
      WAIT_RSP:
        if (start_seen)
          state_d = RECV_RSP;
        else if (rsp_timeout)
          state_d = IDLE;
      RECV_RSP:
        if (rsp_done || rsp_timeout)
          state_d = IDLE;
      FINISH:
        if (!tx_busy)
          state_d = IDLE;
      default:
        state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q  <= IDLE;
      cmd_rdy  <= 1'b0;
      launch_q <= 1'b0;
      read_vld <= 1'b0;
    end
    else
    begin
      state_q  <= state_d;
      cmd_rdy  <= state_d == IDLE;
      launch_q <= accept;                  // Load shifter next cycle
      read_vld <= rsp_done || rsp_timeout;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_buf <= cmd_in;
    end
    if (rsp_done)
    begin
      read_data   <= rx_byte;
      read_status <= rx_status;
    end
    else if (rsp_timeout)
    begin
      read_data   <= '0;
      read_status <= STAT_TIMEOUT;
    end
  end

endmodule

`default_nettype wire

// File: design/uart_cmd_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_bridge
  import uart_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n,
  input  cmd_t        cmd_in,
  input  wire         cmd_vld,
  output logic        cmd_rdy,
  input  wire         rx,
  output logic        tx,
  output uart_byte_t  read_data,
  output rsp_status_t read_status,
  output logic        read_vld
);

  logic       timer_clr;
  logic       timer_run;
  logic       bit_tick;
  logic       mid_tick;
  bit_count_t bit_cnt;
  logic       tx_load;
  uart_byte_t tx_byte;
  logic       tx_busy;
  logic       rx_arm;
  logic       start_seen;
  logic       rx_done;
  uart_byte_t rx_byte;
  logic       parity_ok;
  logic       stop_ok;

  uart_cmd_fsm u_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .read_data  (read_data),
    .read_status(read_status),
    .read_vld   (read_vld),
    .timer_clr  (timer_clr),
    .timer_run  (timer_run),
    .bit_tick   (bit_tick),
    .bit_cnt    (bit_cnt),
    .tx_load    (tx_load),
    .tx_byte    (tx_byte),
    .tx_busy    (tx_busy),
    .rx_arm     (rx_arm),
    .start_seen (start_seen),
    .rx_done    (rx_done),
    .rx_byte    (rx_byte),
    .parity_ok  (parity_ok),
    .stop_ok    (stop_ok)
  );

  // Single timer shared by transmit, gap and receive phases
  baud_timer u_timer (
    .clk      (clk),
    .rst_n    (rst_n),
    .timer_clr(timer_clr),
    .timer_run(timer_run),
    .bit_tick (bit_tick),
    .mid_tick (mid_tick),
    .bit_cnt  (bit_cnt)
  );

  uart_tx_shifter u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_load (tx_load),
    .tx_byte (tx_byte),
    .bit_tick(bit_tick),
    .tx      (tx),
    .tx_busy (tx_busy)
  );

  uart_rx_sampler u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_arm    (rx_arm),
    .mid_tick  (mid_tick),
    .start_seen(start_seen),
    .rx_done   (rx_done),
    .rx_byte   (rx_byte),
    .parity_ok (parity_ok),
    .stop_ok   (stop_ok)
  );

endmodule

`default_nettype wire

// File: sim/tb_uart_cmd_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_cmd_bridge
  import uart_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int HALF_BIT   = BIT_CYCLES / 2;
  localparam int RDY_LIMIT  = 4 * BIT_CYCLES;
  localparam int LINE_LIMIT = 8 * BIT_CYCLES;
  localparam int RSP_LIMIT  = (RSP_TIMEOUT_BITS + 2 * FRAME_BITS) * BIT_CYCLES;
  localparam int RANDOM_OPS = 8;

  logic        clk;
  logic        rst_n;
  cmd_t        cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        rx;
  logic        tx;
  uart_byte_t  read_data;
  rsp_status_t read_status;
  logic        read_vld;

  uart_cmd_bridge uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .rx         (rx),
    .tx         (tx),
    .read_data  (read_data),
    .read_status(read_status),
    .read_vld   (read_vld)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_byte(input uart_byte_t act, input uart_byte_t exp, input string what);
    if (act !== exp)
    begin
      stop_run($sformatf("ERROR at %0d ns: %s is 0x%02h, expected 0x%02h",
                         $time, what, act, exp));
    end
  endtask

  task automatic check_status(input rsp_status_t act, input rsp_status_t exp,
                              input string what);
    if (act !== exp)
    begin
      stop_run($sformatf("ERROR at %0d ns: %s is %0d, expected %0d", $time, what, act, exp));
    end
  endtask

  task automatic check_bit(input logic act, input logic exp, input string what);
    if (act !== exp)
    begin
      stop_run($sformatf("ERROR at %0d ns: %s is %b, expected %b", $time, what, act, exp));
    end
  endtask

  // Counts idle cycles until the line drops
  task automatic wait_tx_low(output int cycles);
    cycles = 0;
    while (tx !== 1'b0)
    begin
      @(negedge clk);
      cycles++;
      if (cycles > LINE_LIMIT)
      begin
        stop_run($sformatf("Timed out at %0d ns waiting for a start bit on tx", $time));
      end
    end
  endtask

  // Samples each bit at its middle
  task automatic decode_frame(output uart_byte_t data, output int idle_cycles);
    logic par_bit;
    wait_tx_low(idle_cycles);
    repeat (HALF_BIT) @(negedge clk);
    check_bit(tx, 1'b0, "tx start bit");
    for (int i = 0; i < BYTE_W; i++)
    begin
      repeat (BIT_CYCLES) @(negedge clk);
      data[i] = tx;
    end
    repeat (BIT_CYCLES) @(negedge clk);
    par_bit = tx;
    repeat (BIT_CYCLES) @(negedge clk);
    check_bit(tx, 1'b1, "tx stop bit");
    check_bit(^{data, par_bit}, 1'b0, "odd count of ones in tx data and parity");
  endtask

  task automatic send_command(input cmd_t cmd);
    int waited;
    @(negedge clk);
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    waited  = 0;
    while (cmd_rdy !== 1'b1)
    begin
      @(negedge clk);
      waited++;
      if (waited > RDY_LIMIT)
      begin
        stop_run($sformatf("Timed out at %0d ns waiting for cmd_rdy", $time));
      end
    end
    @(negedge clk);                         // Accepted on the edge before
    cmd_vld = 1'b0;
    check_bit(cmd_rdy, 1'b0, "cmd_rdy after acceptance");
  endtask

  task automatic wait_cmd_rdy();
    int waited;
    waited = 0;
    while (cmd_rdy !== 1'b1)
    begin
      @(negedge clk);
      waited++;
      if (waited > RDY_LIMIT)
      begin
        stop_run($sformatf("Timed out at %0d ns waiting for the bridge to go idle", $time));
      end
    end
  endtask

  task automatic wait_read_result(output uart_byte_t data, output rsp_status_t status,
                                  output int cycles);
    cycles = 0;
    while (read_vld !== 1'b1)
    begin
      @(negedge clk);
      cycles++;
      if (cycles > RSP_LIMIT)
      begin
        stop_run($sformatf("Timed out at %0d ns waiting for read_vld", $time));
      end
    end
    data   = read_data;
    status = read_status;
    check_bit(cmd_rdy, 1'b1, "cmd_rdy together with read_vld");
    @(negedge clk);
    check_bit(read_vld, 1'b0, "read_vld one cycle after its pulse");
  endtask

  // Responder side of the serial line
  task automatic drive_response(input uart_byte_t data, input logic par_bit,
                                input logic stop_bit, input int delay);
    repeat (delay) @(negedge clk);
    rx = 1'b0;
    repeat (BIT_CYCLES) @(negedge clk);
    for (int i = 0; i < BYTE_W; i++)
    begin
      rx = data[i];
      repeat (BIT_CYCLES) @(negedge clk);
    end
    rx = par_bit;
    repeat (BIT_CYCLES) @(negedge clk);
    rx = stop_bit;
    repeat (BIT_CYCLES) @(negedge clk);
    rx = 1'b1;
  endtask

  task automatic check_write_frames(input cmd_t cmd);
    uart_byte_t data;
    int         idle;
    int         gap_exp;
    gap_exp = HALF_BIT + GAP_BITS * BIT_CYCLES;   // From mid stop bit
    decode_frame(data, idle);
    check_byte(data, cmd[15:8], "write address frame");
    decode_frame(data, idle);
    check_bit((idle >= gap_exp - BIT_CYCLES) && (idle <= gap_exp + BIT_CYCLES), 1'b1,
              $sformatf("gap of %0d cycles within one bit of %0d", idle, gap_exp));
    check_byte(data, cmd[7:0], "write data frame");
  endtask

  task automatic run_write(input cmd_t cmd);
    send_command(cmd);
    check_write_frames(cmd);
    wait_cmd_rdy();
  endtask

  task automatic run_read(input logic [6:0] addr, input uart_byte_t rsp, input logic bad_par,
                          input logic bad_stop, input rsp_status_t exp_status);
    uart_byte_t  frame;
    uart_byte_t  got_data;
    rsp_status_t got_status;
    int          idle;
    int          cycles;
    int          delay;
    send_command({1'b0, addr, uart_byte_t'($urandom)});
    decode_frame(frame, idle);
    check_byte(frame, {1'b0, addr}, "read address frame");
    delay = BIT_CYCLES + $urandom_range(4 * BIT_CYCLES);   // Responder latency
    fork
      drive_response(rsp, (^rsp) ^ bad_par, ~bad_stop, delay);
      wait_read_result(got_data, got_status, cycles);
    join
    check_status(got_status, exp_status, "read status");
    check_byte(got_data, rsp, "read data");
  endtask

  task automatic reset_values();
    @(negedge clk);
    check_bit(tx, 1'b1, "tx after reset");
    check_bit(cmd_rdy, 1'b1, "cmd_rdy after reset");
    check_bit(read_vld, 1'b0, "read_vld after reset");
  endtask

  // A second command held during a write must not start another frame
  task automatic busy_ignores_cmd();
    cmd_t cmd;
    cmd = {1'b1, 7'h2a, 8'hc3};
    send_command(cmd);
    fork
      begin
        cmd_in  = cmd ^ 16'h7fff;
        cmd_vld = 1'b1;
        repeat (3 * BIT_CYCLES)
        begin
          @(negedge clk);
          check_bit(cmd_rdy, 1'b0, "cmd_rdy while busy");
        end
        cmd_vld = 1'b0;
      end
      check_write_frames(cmd);
    join
    wait_cmd_rdy();
    repeat (2 * BIT_CYCLES)
    begin
      @(negedge clk);
      check_bit(tx, 1'b1, "tx idle after write");
    end
  endtask

  task automatic read_timeout();
    uart_byte_t  frame;
    uart_byte_t  got_data;
    rsp_status_t got_status;
    int          idle;
    int          cycles;
    int          exp_cycles;
    exp_cycles = HALF_BIT + RSP_TIMEOUT_BITS * BIT_CYCLES;
    send_command({1'b0, 7'h11, 8'h5a});
    decode_frame(frame, idle);
    check_byte(frame, 8'h11, "read address frame");
    wait_read_result(got_data, got_status, cycles);
    check_status(got_status, STAT_TIMEOUT, "timeout status");
    check_byte(got_data, '0, "timeout read data");
    check_bit((cycles >= exp_cycles - BIT_CYCLES) && (cycles <= exp_cycles + BIT_CYCLES), 1'b1,
              $sformatf("timeout after %0d cycles near %0d", cycles, exp_cycles));
    wait_cmd_rdy();
  endtask

  task automatic random_mix();
    cmd_t cmd;
    for (int i = 0; i < RANDOM_OPS; i++)
    begin
      cmd = cmd_t'($urandom);
      if (cmd[15])
      begin
        run_write(cmd);
      end
      else
      begin
        run_read(cmd[14:8], uart_byte_t'($urandom), 1'b0, 1'b0, STAT_OK);
      end
    end
  endtask

  initial
  begin
    void'($urandom(11));
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    reset_values();
    busy_ignores_cmd();
    run_write({1'b1, 7'h05, 8'h3c});
    run_write({1'b1, 7'h7f, 8'h00});
    run_read(7'h33, uart_byte_t'($urandom), 1'b0, 1'b0, STAT_OK);
    run_read(7'h12, 8'ha7, 1'b1, 1'b0, STAT_PARITY);
    run_read(7'h44, 8'h81, 1'b0, 1'b1, STAT_FRAME);
    run_read(7'h09, 8'h6e, 1'b1, 1'b1, STAT_FRAME);   // Stop error wins
    read_timeout();
    random_mix();
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
design/uart_pkg.sv
design/baud_timer.sv
design/uart_tx_shifter.sv
design/uart_rx_sampler.sv
design/uart_cmd_fsm.sv
design/uart_cmd_bridge.sv
sim/tb_uart_cmd_bridge.sv

// File: Bender.yml
package:
  name: uart_cmd_bridge

sources:
  - design/uart_pkg.sv
  - design/baud_timer.sv
  - design/uart_tx_shifter.sv
  - design/uart_rx_sampler.sv
  - design/uart_cmd_fsm.sv
  - design/uart_cmd_bridge.sv
  - target: simulation
    files:
      - sim/tb_uart_cmd_bridge.sv
